//--- dcache_lite.f
hw/dcache_pkg.sv
hw/tlb_lookup.sv
hw/access_queue.sv
hw/cache_arbiter.sv
hw/cache_bank.sv
hw/dcache_top.sv
tb/tb_dcache.sv

//--- hw/access_queue.sv
`timescale 1ns/1ps

module access_queue
   import dcache_pkg::*;
#(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         push_i,
   input  queue_entry_t entry_i,
   input  logic         pop_i,
   output queue_entry_t head_o,
   output logic         empty_o,
   output logic         full_o
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   queue_entry_t     mem_q [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_push;
   logic             do_pop;

   // Pointer step with wrap for non power of two depths
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full_o  = (count_q == CNT_W'(QUEUE_DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;
   assign head_o  = mem_q[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= entry_i;
      end
   end

endmodule

//--- hw/cache_arbiter.sv
`timescale 1ns/1ps

module cache_arbiter
   import dcache_pkg::*;
(
   input  fill_t        fill_i,
   input  queue_entry_t rd_head_i,
   input  logic         rd_empty_i,
   input  queue_entry_t wr_head_i,
   input  logic         wr_empty_i,
   input  logic         miss_pending_i,
   output logic         rd_pop_o,
   output logic         wr_pop_o,
   output cache_req_t   req_o
);

   always_comb begin
      req_o = '0;
      req_o.op = OP_NONE;
      rd_pop_o = 1'b0;
      wr_pop_o = 1'b0;

      if (fill_i.valid) begin
         req_o.op = OP_FILL;
         req_o.paddr = {fill_i.line_addr, {LINE_OFS_W{1'b0}}};
         req_o.line = fill_i.line;
      end else if (miss_pending_i) begin
         // Queues hold until the line arrives
         req_o.op = OP_NONE;
      end else if (!wr_empty_i) begin
         req_o.op = OP_WRITE;
         req_o.paddr = wr_head_i.paddr;
         req_o.data = wr_head_i.data;
         wr_pop_o = 1'b1;
      end else if (!rd_empty_i) begin
         req_o.op = OP_READ;
         req_o.paddr = rd_head_i.paddr;
         req_o.data = rd_head_i.data;
         rd_pop_o = 1'b1;
      end
   end

endmodule

//--- hw/cache_bank.sv
`timescale 1ns/1ps

module cache_bank
   import dcache_pkg::*;
#(
   parameter int NUM_LINES = 32
) (
   input  logic       clk,
   input  logic       rst_n_i,
   input  cache_req_t req_i,
   output logic       miss_pending_o,
   output rd_resp_t   rd_resp_o,
   output mem_rd_t    mem_rd_o,
   output mem_wr_t    mem_wr_o
);

   localparam int WSEL_W = $clog2(WORDS_PER_LINE);

   tag_t                 tag_mem  [NUM_LINES];
   line_t                line_mem [NUM_LINES];
   logic [NUM_LINES-1:0] valid_q;
   bank_state_e          state_q;
   paddr_t               miss_addr_q;

   index_t               req_idx;
   tag_t                 req_tag;
   logic [WSEL_W-1:0]    req_wsel;
   logic                 hit;
   logic                 fill_ok;

   function automatic word_t pick_word(input line_t line, input paddr_t addr);
      return line[addr[LINE_OFS_W-1 -: WSEL_W]*WORD_W +: WORD_W];
   endfunction

   assign req_idx  = req_i.paddr[LINE_OFS_W +: INDEX_W];
   assign req_tag  = req_i.paddr[PADDR_W-1 -: TAG_W];
   assign req_wsel = req_i.paddr[LINE_OFS_W-1 -: WSEL_W];
   assign hit      = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
   assign fill_ok  = (req_i.op == OP_FILL) && (state_q == BANK_WAIT_FILL);

   assign miss_pending_o = (state_q == BANK_WAIT_FILL);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= BANK_IDLE;
         valid_q <= '0;
         rd_resp_o.valid <= 1'b0;
         mem_rd_o.valid <= 1'b0;
         mem_wr_o.valid <= 1'b0;
      end else begin
         rd_resp_o.valid <= 1'b0;
         mem_rd_o.valid <= 1'b0;
         mem_wr_o.valid <= 1'b0;
         case (req_i.op)
            OP_READ: begin
               if (hit) begin
                  rd_resp_o.valid <= 1'b1;
                  rd_resp_o.paddr <= req_i.paddr;
                  rd_resp_o.data <= pick_word(line_mem[req_idx], req_i.paddr);
               end else begin
                  mem_rd_o.valid <= 1'b1;
                  mem_rd_o.line_addr <= req_i.paddr[PADDR_W-1:LINE_OFS_W];
                  miss_addr_q <= req_i.paddr;
                  state_q <= BANK_WAIT_FILL;
               end
            end
            // Write-through, memory sees every write
            OP_WRITE: begin
               mem_wr_o.valid <= 1'b1;
               mem_wr_o.paddr <= req_i.paddr;
               mem_wr_o.data <= req_i.data;
            end
            OP_FILL: begin
               if (fill_ok) begin
                  valid_q[req_idx] <= 1'b1;
                  rd_resp_o.valid <= 1'b1;
                  rd_resp_o.paddr <= miss_addr_q;
                  rd_resp_o.data <= pick_word(req_i.line, miss_addr_q);
                  state_q <= BANK_IDLE;
               end
            end
            default: ;
         endcase
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk) begin
      if (fill_ok) begin
         tag_mem[req_idx] <= req_tag;
         line_mem[req_idx] <= req_i.line;
      end else if (req_i.op == OP_WRITE && hit) begin
         line_mem[req_idx][req_wsel*WORD_W +: WORD_W] <= req_i.data;
      end
   end

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

   localparam int VADDR_W        = 32;
   localparam int PADDR_W        = 15;
   localparam int PAGE_OFS_W     = 12;
   localparam int VPN_W          = 20;
   localparam int PFN_W          = 3;
   localparam int WORD_W         = 32;
   localparam int LINE_W         = 128;
   localparam int WORDS_PER_LINE = 4;
   localparam int LINE_OFS_W     = 4;
   localparam int INDEX_W        = 5;
   localparam int TAG_W          = 6;

   typedef logic [VADDR_W-1:0]            vaddr_t;
   typedef logic [PADDR_W-1:0]            paddr_t;
   typedef logic [VPN_W-1:0]              vpn_t;
   typedef logic [PFN_W-1:0]              pfn_t;
   typedef logic [WORD_W-1:0]             word_t;
   typedef logic [LINE_W-1:0]             line_t;
   typedef logic [PADDR_W-LINE_OFS_W-1:0] line_addr_t;
   typedef logic [INDEX_W-1:0]            index_t;
   typedef logic [TAG_W-1:0]              tag_t;

   typedef enum logic [1:0] {OP_NONE, OP_READ, OP_WRITE, OP_FILL} op_kind_e;
   typedef enum logic {BANK_IDLE, BANK_WAIT_FILL} bank_state_e;

   // One TLB slot as loaded by the page-table handler
   typedef struct packed {logic valid; logic writable; vpn_t vpn; pfn_t pfn;} tlb_entry_t;

   typedef struct packed {logic tlb_miss; logic prot;} exc_t;

   typedef struct packed {paddr_t paddr; word_t data;} queue_entry_t;

   typedef struct packed {logic valid; paddr_t paddr; word_t data;} rd_resp_t;

   typedef struct packed {logic valid; line_addr_t line_addr;} mem_rd_t;

   typedef struct packed {logic valid; paddr_t paddr; word_t data;} mem_wr_t;

   typedef struct packed {logic valid; line_addr_t line_addr; line_t line;} fill_t;

   typedef struct packed {op_kind_e op; paddr_t paddr; word_t data; line_t line;} cache_req_t;

endpackage

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
#(
   parameter int TLB_ENTRIES = 8,
   parameter int QUEUE_DEPTH = 4,
   parameter int NUM_LINES   = 32
) (
   input  logic                          clk,
   input  logic                          rst_n_i,
   input  tlb_entry_t [TLB_ENTRIES-1:0]  tlb_entries_i,
   input  logic                          rd_valid_i,
   input  vaddr_t                        rd_vaddr_i,
   input  logic                          wr_valid_i,
   input  vaddr_t                        wr_vaddr_i,
   input  word_t                         wr_data_i,
   input  fill_t                         fill_i,
   output logic                          rd_full_o,
   output logic                          wr_full_o,
   output exc_t                          rd_exc_o,
   output exc_t                          wr_exc_o,
   output rd_resp_t                      rd_resp_o,
   output mem_rd_t                       mem_rd_o,
   output mem_wr_t                       mem_wr_o
);

   logic         rd_push, wr_push;
   logic         rd_pop, wr_pop;
   logic         rd_empty, wr_empty;
   logic         miss_pending;
   queue_entry_t rd_entry, wr_entry;
   queue_entry_t rd_head, wr_head;
   cache_req_t   bank_req;

   // Read path, no protection check
   tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_rd_tlb (
      .clk(clk), .rst_n_i(rst_n_i), .valid_i(rd_valid_i), .vaddr_i(rd_vaddr_i),
      .data_i('0), .check_write_i(1'b0), .entries_i(tlb_entries_i),
      .push_o(rd_push), .entry_o(rd_entry), .exc_o(rd_exc_o)
   );

   tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_wr_tlb (
      .clk(clk), .rst_n_i(rst_n_i), .valid_i(wr_valid_i), .vaddr_i(wr_vaddr_i),
      .data_i(wr_data_i), .check_write_i(1'b1), .entries_i(tlb_entries_i),
      .push_o(wr_push), .entry_o(wr_entry), .exc_o(wr_exc_o)
   );

   access_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_rd_queue (
      .clk(clk), .rst_n_i(rst_n_i), .push_i(rd_push), .entry_i(rd_entry),
      .pop_i(rd_pop), .head_o(rd_head), .empty_o(rd_empty), .full_o(rd_full_o)
   );

   access_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_wr_queue (
      .clk(clk), .rst_n_i(rst_n_i), .push_i(wr_push), .entry_i(wr_entry),
      .pop_i(wr_pop), .head_o(wr_head), .empty_o(wr_empty), .full_o(wr_full_o)
   );

   cache_arbiter u_arbiter (
      .fill_i(fill_i), .rd_head_i(rd_head), .rd_empty_i(rd_empty),
      .wr_head_i(wr_head), .wr_empty_i(wr_empty), .miss_pending_i(miss_pending),
      .rd_pop_o(rd_pop), .wr_pop_o(wr_pop), .req_o(bank_req)
   );

   cache_bank #(.NUM_LINES(NUM_LINES)) u_bank (
      .clk(clk), .rst_n_i(rst_n_i), .req_i(bank_req), .miss_pending_o(miss_pending),
      .rd_resp_o(rd_resp_o), .mem_rd_o(mem_rd_o), .mem_wr_o(mem_wr_o)
   );

endmodule

//--- hw/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup
   import dcache_pkg::*;
#(
   parameter int TLB_ENTRIES = 8
) (
   input  logic                          clk,
   input  logic                          rst_n_i,
   input  logic                          valid_i,
   input  vaddr_t                        vaddr_i,
   input  word_t                         data_i,
   input  logic                          check_write_i,
   input  tlb_entry_t [TLB_ENTRIES-1:0]  entries_i,
   output logic                          push_o,
   output queue_entry_t                  entry_o,
   output exc_t                          exc_o
);

   logic       hit;
   tlb_entry_t hit_entry;
   logic       prot_fault;

   // Parallel compare, lowest slot wins
   always_comb begin
      hit = 1'b0;
      hit_entry = '0;
      for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
         if (entries_i[i].valid && entries_i[i].vpn == vaddr_i[VADDR_W-1:PAGE_OFS_W]) begin
            hit = 1'b1;
            hit_entry = entries_i[i];
         end
      end
   end

   assign prot_fault = hit && check_write_i && !hit_entry.writable;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         push_o <= 1'b0;
         exc_o <= '0;
      end else begin
         push_o <= valid_i && hit && !prot_fault;
         exc_o.tlb_miss <= valid_i && !hit;
         exc_o.prot <= valid_i && prot_fault;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_i) begin
         entry_o.paddr <= {hit_entry.pfn, vaddr_i[PAGE_OFS_W-1:0]};
         entry_o.data <= data_i;
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the data-cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_dcache \
   -f dcache_lite.f -o sim_dcache

# The simulation exits non-zero on failure, the log decides the result
./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

//--- tb/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
   import dcache_pkg::*;
();

   localparam int TLB_ENTRIES = 8;
   localparam int QUEUE_DEPTH = 4;
   localparam int NUM_LINES   = 32;
   localparam int NUM_ROWS    = 25;
   localparam int HOLD_DELAY  = 30;
   localparam int WATCHDOG    = NUM_ROWS * 20 + 50;
   localparam logic RD = 1'b0;
   localparam logic WR = 1'b1;
   localparam exc_t NO_EXC   = 2'b00;
   localparam exc_t TLB_MISS = 2'b10;
   localparam exc_t PROT     = 2'b01;

   typedef struct packed {
      logic   is_write;
      logic   hold;
      vaddr_t vaddr;
      word_t  data;
      exc_t   exc;
   } row_t;

   typedef struct packed {logic miss; paddr_t paddr;} rd_exp_t;

   logic                         clk;
   logic                         rst_n;
   tlb_entry_t [TLB_ENTRIES-1:0] tlb_entries;
   logic                         rd_valid;
   logic                         wr_valid;
   vaddr_t                       rd_vaddr;
   vaddr_t                       wr_vaddr;
   word_t                        wr_data;
   fill_t                        fill;
   logic                         rd_full;
   logic                         wr_full;
   exc_t                         rd_exc;
   exc_t                         wr_exc;
   rd_resp_t                     rd_resp;
   mem_rd_t                      mem_rd;
   mem_wr_t                      mem_wr;

   row_t       rows [NUM_ROWS];
   word_t      mem_model [int];
   rd_exp_t    rd_sb [$];
   mem_wr_t    wr_sb [$];
   logic       line_valid [NUM_LINES] = '{default: 1'b0};
   tag_t       line_tag [NUM_LINES];
   word_t      rng = 32'd97;
   exc_t       rd_exc_exp = '0;
   exc_t       wr_exc_exp = '0;
   logic       miss_seen = 1'b0;
   logic       saw_rd_full = 1'b0;
   logic       hold_fill = 1'b0;
   int         fill_wait = 0;
   line_addr_t fill_line;
   int         cyc = 0;
   int         rd_next_cyc = 0;
   int         wr_next_cyc = 0;
   logic [2:0] rd_push_pipe = '0;
   logic [2:0] wr_push_pipe = '0;
   int         rd_q_cnt = 0;
   int         wr_q_cnt = 0;

   dcache_top #(
      .TLB_ENTRIES(TLB_ENTRIES),
      .QUEUE_DEPTH(QUEUE_DEPTH),
      .NUM_LINES(NUM_LINES)
   ) UUT (
      .clk(clk), .rst_n_i(rst_n), .tlb_entries_i(tlb_entries),
      .rd_valid_i(rd_valid), .rd_vaddr_i(rd_vaddr), .wr_valid_i(wr_valid),
      .wr_vaddr_i(wr_vaddr), .wr_data_i(wr_data), .fill_i(fill),
      .rd_full_o(rd_full), .wr_full_o(wr_full), .rd_exc_o(rd_exc), .wr_exc_o(wr_exc),
      .rd_resp_o(rd_resp), .mem_rd_o(mem_rd), .mem_wr_o(mem_wr)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("Timeout: the run did not end within %0d cycles", WATCHDOG);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

   function automatic word_t xorshift32(input word_t s);
      word_t x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Pages 0 to 5 map one to one, page 6 lands on frame 1
   function automatic paddr_t expected_paddr(input vaddr_t va);
      pfn_t frame;
      frame = pfn_t'(va[PAGE_OFS_W +: PFN_W]);
      if (va[VADDR_W-1:PAGE_OFS_W] == vpn_t'(6)) begin
         frame = pfn_t'(1);
      end
      return {frame, va[PAGE_OFS_W-1:0]};
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_resp(input rd_resp_t got, input rd_resp_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail rd_resp_o got %h expected %h", got, exp));
      end
   endtask

   task automatic check_mem_wr(input mem_wr_t got, input mem_wr_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail mem_wr_o got %h expected %h", got, exp));
      end
   endtask

   task automatic check_mem_rd(input mem_rd_t got, input mem_rd_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail mem_rd_o got %h expected %h", got, exp));
      end
   endtask

   task automatic check_exc(input string name, input exc_t got, input exc_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_full(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_error($sformatf("Fail %s got %h expected %h", name, got, exp));
      end
   endtask

   // Memory side answers a line request after the chosen delay
   task automatic serve_fill();
      line_t line;
      if (fill_wait > 0) begin
         fill_wait--;
         if (fill_wait == 0) begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
               line[i*WORD_W +: WORD_W] = mem_model[int'(fill_line) * WORDS_PER_LINE + i];
            end
            fill.valid = 1'b1;
            fill.line_addr = fill_line;
            fill.line = line;
         end
      end
   endtask

   task automatic check_outputs();
      rd_exp_t head;
      if (rd_full) begin
         saw_rd_full = 1'b1;
      end
      // A clean strobe lands in its queue two edges later
      rd_q_cnt += int'(rd_push_pipe[2]);
      wr_q_cnt += int'(wr_push_pipe[2]);
      check_exc("rd_exc_o", rd_exc, rd_exc_exp);
      check_exc("wr_exc_o", wr_exc, wr_exc_exp);
      rd_exc_exp = NO_EXC;
      wr_exc_exp = NO_EXC;
      if (mem_wr.valid) begin
         if (wr_sb.size() == 0) begin
            stop_with_error("mem_wr_o fired with no write outstanding");
         end
         check_mem_wr(mem_wr, wr_sb.pop_front());
         mem_model[int'(mem_wr.paddr[PADDR_W-1:2])] = mem_wr.data;
         wr_q_cnt--;
      end
      if (mem_rd.valid) begin
         if (rd_sb.size() == 0 || miss_seen) begin
            stop_with_error("mem_rd_o fired with no read waiting for a line");
         end
         head = rd_sb[0];
         check_mem_rd(mem_rd, {1'b1, head.paddr[PADDR_W-1:LINE_OFS_W]});
         miss_seen = 1'b1;
         rd_q_cnt--;
         rng = xorshift32(rng);
         fill_wait = hold_fill ? HOLD_DELAY : 2 + int'(rng % 8);
         hold_fill = 1'b0;
         fill_line = mem_rd.line_addr;
      end
      if (rd_resp.valid) begin
         if (rd_sb.size() == 0) begin
            stop_with_error("rd_resp_o fired with no read outstanding");
         end
         head = rd_sb.pop_front();
         if (head.miss != miss_seen) begin
            stop_with_error($sformatf("Read of %h did not hit or miss as the cache state says",
                                      head.paddr));
         end
         // A missed read left its queue at the grant before mem_rd_o
         if (!head.miss) begin
            rd_q_cnt--;
         end
         miss_seen = 1'b0;
         check_resp(rd_resp, {1'b1, head.paddr, mem_model[int'(head.paddr[PADDR_W-1:2])]});
      end
      check_full("rd_full_o", rd_full, rd_q_cnt == QUEUE_DEPTH);
      check_full("wr_full_o", wr_full, wr_q_cnt == QUEUE_DEPTH);
   endtask

   task automatic step();
      @(negedge clk);
      cyc++;
      rd_valid = 1'b0;
      wr_valid = 1'b0;
      fill = '0;
      rd_push_pipe = rd_push_pipe << 1;
      wr_push_pipe = wr_push_pipe << 1;
      serve_fill();
      check_outputs();
   endtask

   // Same-path strobes are two cycles apart so full is current
   task automatic apply_row(input row_t r);
      paddr_t pa;
      index_t idx;
      logic   miss;
      pa = expected_paddr(r.vaddr);
      idx = pa[LINE_OFS_W +: INDEX_W];
      if (r.hold) begin
         while (rd_sb.size() != 0) begin
            step();
         end
         hold_fill = 1'b1;
      end
      if (r.is_write) begin
         while (wr_full || cyc < wr_next_cyc) begin
            step();
         end
         wr_valid = 1'b1;
         wr_vaddr = r.vaddr;
         wr_data = r.data;
         wr_exc_exp = r.exc;
         wr_next_cyc = cyc + 2;
         if (r.exc == NO_EXC) begin
            wr_sb.push_back({1'b1, pa, r.data});
            wr_push_pipe[0] = 1'b1;
         end
      end else begin
         while (rd_full || cyc < rd_next_cyc) begin
            step();
         end
         rd_valid = 1'b1;
         rd_vaddr = r.vaddr;
         rd_exc_exp = r.exc;
         rd_next_cyc = cyc + 2;
         if (r.exc == NO_EXC) begin
            miss = !(line_valid[idx] && line_tag[idx] == pa[PADDR_W-1 -: TAG_W]);
            line_valid[idx] = 1'b1;
            line_tag[idx] = pa[PADDR_W-1 -: TAG_W];
            rd_sb.push_back({miss, pa});
            rd_push_pipe[0] = 1'b1;
         end
      end
      step();
   endtask

   initial begin
      rst_n = 1'b0;
      rd_valid = 1'b0;
      wr_valid = 1'b0;
      rd_vaddr = '0;
      wr_vaddr = '0;
      wr_data = '0;
      fill = '0;
      tlb_entries = '0;
      for (int i = 0; i < 6; i++) begin
         tlb_entries[i].valid = 1'b1;
         tlb_entries[i].writable = (i != 3);
         tlb_entries[i].vpn = vpn_t'(i);
         tlb_entries[i].pfn = pfn_t'(i);
      end
      tlb_entries[6] = {1'b1, 1'b1, vpn_t'(6), pfn_t'(1)};
      for (int a = 0; a < 2 ** (PADDR_W - 2); a++) begin
         rng = xorshift32(rng);
         mem_model[a] = rng;
      end
      rows = '{
         {RD, 1'b0, 32'h0000_0010, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_0014, 32'h0, NO_EXC},
         {WR, 1'b0, 32'h0000_0018, 32'hA5A5_0001, NO_EXC},
         {RD, 1'b0, 32'h0000_0018, 32'h0, NO_EXC},
         {WR, 1'b0, 32'h0000_2040, 32'h1234_5678, NO_EXC},
         {RD, 1'b0, 32'h0000_2040, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_7000, 32'h0, TLB_MISS},
         {WR, 1'b0, 32'h0001_2344, 32'hDEAD_BEEF, TLB_MISS},
         {WR, 1'b0, 32'h0000_3100, 32'hBAD0_0003, PROT},
         {RD, 1'b0, 32'h0000_3100, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_1200, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_6200, 32'h0, NO_EXC},
         {WR, 1'b0, 32'h0000_6204, 32'h0A11_A5ED, NO_EXC},
         {RD, 1'b0, 32'h0000_1204, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_5010, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_0010, 32'h0, NO_EXC},
         // Held fill, the reads behind it fill the queue
         {RD, 1'b1, 32'h0000_4300, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_4304, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_4308, 32'h0, NO_EXC},
         {WR, 1'b0, 32'h0000_4308, 32'h5555_AAAA, NO_EXC},
         {RD, 1'b0, 32'h0000_430C, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_0400, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_2400, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_4308, 32'h0, NO_EXC},
         {RD, 1'b0, 32'h0000_6208, 32'h0, NO_EXC}
      };
      repeat (2) step();
      rst_n = 1'b1;
      for (int n = 0; n < NUM_ROWS; n++) begin
         apply_row(rows[n]);
      end
      while (rd_sb.size() != 0 || wr_sb.size() != 0) begin
         step();
      end
      repeat (5) step();
      if (!saw_rd_full) begin
         $display("rd_full_o never rose while the fill was held back");
         $display("Finished with errors");
         $fatal(1, "read queue never filled");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule
